// File: tpu_cfg_pkg.sv
// TPU data path configuration

package tpu_cfg_pkg;

    // array and matrix dimension
    localparam int dim = 8;

    // words in one half-row of the host interface
    localparam int half = dim / 2;

    // element width, signed two's complement
    localparam int data_w = 32;

    // bits needed to address one row
    localparam int row_w = $clog2(dim);

    typedef logic signed [data_w-1:0] elem_t;

    // four words, w[3] is the leftmost column of the half
    typedef struct packed {
        elem_t [half-1:0] w;
    } half_row_t;

    // full row, col[7:4] is the high half and col[3:0] the low half
    typedef struct packed {
        elem_t [dim-1:0] col;
    } row_t;

    // operand vector entering one side of the array
    typedef struct packed {
        elem_t [dim-1:0] lane;
    } edge_t;

endpackage

// File: tpu_op_pkg.sv
// TPU command definitions

package tpu_op_pkg;

    // host opcodes, encoding fixed by the host software
    typedef enum logic [2:0] {
        nop           = 3'd0,
        writeA        = 3'd1,
        writeB        = 3'd2,
        writeC        = 3'd3,
        matmul        = 3'd4,
        readC         = 3'd5,
        systolic_step = 3'd6
    } opcode_t;

    // only the low bits of idx select a row
    localparam int idx_w = 4;

    localparam int step_w = 5;

    // skew fill, dim steps of data and skew drain
    localparam logic [step_w-1:0] n_steps = step_w'(3 * tpu_cfg_pkg::dim - 2);

    typedef struct packed {
        opcode_t          op;
        logic [idx_w-1:0] idx;
        logic             hl;
    } cmd_t;

endpackage

// File: tpu_operand_mem.sv
// TPU operand matrix store

`timescale 1ns/10ps

module tpu_operand_mem
    import tpu_cfg_pkg::*;
    import tpu_op_pkg::*;
#(
    // 0: lanes are rows (A, left edge), 1: lanes are columns (B, top edge)
    parameter bit by_column = 1'b0
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wr,
    input  logic [row_w-1:0]  row_sel,
    input  half_row_t         row_hi,
    input  half_row_t         row_lo,
    input  logic [step_w-1:0] step,
    output edge_t             feed
);

    row_t mem [dim];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < dim; r++) begin
                mem[r] <= '0;
            end
        end else if (wr) begin
            mem[row_sel] <= row_t'({row_hi, row_lo});
        end
    end

    // lane l carries element k = step - l, zero outside the window
    always_comb begin
        int k;
        feed = '0;
        for (int l = 0; l < dim; l++) begin
            k = int'(step) - l;
            if (k >= 0 && k < dim) begin
                if (by_column) begin
                    feed.lane[l] = mem[k].col[l];
                end else begin
                    feed.lane[l] = mem[l].col[k];
                end
            end
        end
    end

endmodule

// File: tpu_step_counter.sv
// Systolic step counter

`timescale 1ns/10ps

module tpu_step_counter
    import tpu_op_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              step_en,
    input  logic              clr_steps,
    output logic [step_w-1:0] step
);

    logic at_end;

    // once the product is complete further steps only feed zeros
    assign at_end = (step >= n_steps);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step <= '0;
        end else if (clr_steps) begin
            // new operands or preload start a fresh product
            step <= '0;
        end else if (step_en && !at_end) begin
            step <= step + 1'b1;
        end
    end

endmodule

// File: tpu_sequencer.sv
// TPU command sequencer

`timescale 1ns/10ps

module tpu_sequencer
    import tpu_cfg_pkg::*;
    import tpu_op_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  cmd_t              cmd,
    input  logic [step_w-1:0] step,
    output logic              wr_a,
    output logic              wr_b,
    output logic              wr_c,
    output logic              rd_c,
    output logic              step_en,
    output logic              clr_steps,
    output logic [row_w-1:0]  row_sel,
    output logic              half_sel
);

    typedef enum logic {
        s_idle,
        s_run
    } state_t;

    state_t state;
    state_t state_nxt;

    assign row_sel  = cmd.idx[row_w-1:0];
    assign half_sel = cmd.hl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        wr_a      = 1'b0;
        wr_b      = 1'b0;
        wr_c      = 1'b0;
        rd_c      = 1'b0;
        step_en   = 1'b0;
        clr_steps = 1'b0;
        case (state)
            s_idle: begin
                case (cmd.op)
                    writeA: begin
                        wr_a      = 1'b1;
                        clr_steps = 1'b1;
                    end
                    writeB: begin
                        wr_b      = 1'b1;
                        clr_steps = 1'b1;
                    end
                    writeC: begin
                        wr_c      = 1'b1;
                        clr_steps = 1'b1;
                    end
                    readC:         rd_c      = 1'b1;
                    systolic_step: step_en   = 1'b1;
                    matmul:        state_nxt = s_run;
                    default: ;
                endcase
            end
            s_run: begin
                // run only the steps still missing, host commands are dropped
                step_en = (step < n_steps);
                if (step >= n_steps - 1'b1) begin
                    state_nxt = s_idle;
                end
            end
            default: state_nxt = s_idle;
        endcase
    end

endmodule

// File: tpu_mac_pe.sv
// Systolic multiply-accumulate cell

`timescale 1ns/10ps

module tpu_mac_pe
    import tpu_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  en,
    input  elem_t a_in,
    input  elem_t b_in,
    input  logic  load,
    input  elem_t load_val,
    output elem_t a_out,
    output elem_t b_out,
    output elem_t acc
);

    // operand pipeline, A moves right and B moves down
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_out <= '0;
            b_out <= '0;
        end else if (en) begin
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    // product and sum wrap at 32 bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (load) begin
            acc <= load_val;
        end else if (en) begin
            acc <= acc + a_in * b_in;
        end
    end

endmodule

// File: tpu_systolic_array.sv
// Output-stationary systolic array

`timescale 1ns/10ps

module tpu_systolic_array
    import tpu_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             step_en,
    input  edge_t            left,
    input  edge_t            top,
    input  logic             wr_c,
    input  logic             rd_c,
    input  logic [row_w-1:0] row_sel,
    input  logic             half_sel,
    input  half_row_t        c_hi,
    input  half_row_t        c_lo,
    output half_row_t        data_out
);

    elem_t a_in_w  [dim][dim];
    elem_t b_in_w  [dim][dim];
    elem_t a_out_w [dim][dim];
    elem_t b_out_w [dim][dim];
    elem_t acc_w   [dim][dim];

    logic [dim-1:0] load_row;
    row_t           c_row;

    // preload row as seen by the cells, col[j] goes to column j
    assign c_row = row_t'({c_hi, c_lo});

    for (genvar i = 0; i < dim; i++) begin : g_row
        assign load_row[i] = wr_c && (row_sel == row_w'(i));

        for (genvar j = 0; j < dim; j++) begin : g_col
            // left column takes the A edge, others the neighbour on the left
            if (j == 0) begin : g_a_edge
                assign a_in_w[i][j] = left.lane[i];
            end else begin : g_a_pass
                assign a_in_w[i][j] = a_out_w[i][j-1];
            end

            // top row takes the B edge, others the neighbour above
            if (i == 0) begin : g_b_edge
                assign b_in_w[i][j] = top.lane[j];
            end else begin : g_b_pass
                assign b_in_w[i][j] = b_out_w[i-1][j];
            end

            tpu_mac_pe u_pe (
                .clk      (clk),
                .arst_n   (arst_n),
                .en       (step_en),
                .a_in     (a_in_w[i][j]),
                .b_in     (b_in_w[i][j]),
                .load     (load_row[i]),
                .load_val (c_row.col[j]),
                .a_out    (a_out_w[i][j]),
                .b_out    (b_out_w[i][j]),
                .acc      (acc_w[i][j])
            );
        end
    end

    // half-row readout, hl high selects columns 7 to 4
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_out <= '0;
        end else if (rd_c) begin
            for (int j = 0; j < half; j++) begin
                if (half_sel) begin
                    data_out.w[j] <= acc_w[row_sel][j+half];
                end else begin
                    data_out.w[j] <= acc_w[row_sel][j];
                end
            end
        end
    end

endmodule

// File: tpuv1.sv
// Matrix multiply accelerator top level

`timescale 1ns/10ps

module tpuv1
    import tpu_cfg_pkg::*;
    import tpu_op_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    input  logic             hl,
    input  half_row_t        v_high,
    input  half_row_t        v_low,
    input  logic [idx_w-1:0] idx,
    input  opcode_t          opcode,
    output half_row_t        data_out
);

    cmd_t              cmd;
    logic              wr_a;
    logic              wr_b;
    logic              wr_c;
    logic              rd_c;
    logic              step_en;
    logic              clr_steps;
    logic [row_w-1:0]  row_sel;
    logic              half_sel;
    logic [step_w-1:0] step;
    edge_t             left_edge;
    edge_t             top_edge;

    assign cmd = '{op: opcode, idx: idx, hl: hl};

    tpu_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd       (cmd),
        .step      (step),
        .wr_a      (wr_a),
        .wr_b      (wr_b),
        .wr_c      (wr_c),
        .rd_c      (rd_c),
        .step_en   (step_en),
        .clr_steps (clr_steps),
        .row_sel   (row_sel),
        .half_sel  (half_sel)
    );

    tpu_step_counter u_cnt (
        .clk       (clk),
        .arst_n    (arst_n),
        .step_en   (step_en),
        .clr_steps (clr_steps),
        .step      (step)
    );

    // A rows enter from the left
    tpu_operand_mem #(.by_column(1'b0)) u_mem_a (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (wr_a),
        .row_sel (row_sel),
        .row_hi  (v_high),
        .row_lo  (v_low),
        .step    (step),
        .feed    (left_edge)
    );

    // B columns enter from the top
    tpu_operand_mem #(.by_column(1'b1)) u_mem_b (
        .clk     (clk),
        .arst_n  (arst_n),
        .wr      (wr_b),
        .row_sel (row_sel),
        .row_hi  (v_high),
        .row_lo  (v_low),
        .step    (step),
        .feed    (top_edge)
    );

    tpu_systolic_array u_array (
        .clk      (clk),
        .arst_n   (arst_n),
        .step_en  (step_en),
        .left     (left_edge),
        .top      (top_edge),
        .wr_c     (wr_c),
        .rd_c     (rd_c),
        .row_sel  (row_sel),
        .half_sel (half_sel),
        .c_hi     (v_high),
        .c_lo     (v_low),
        .data_out (data_out)
    );

endmodule

// File: tb_tpuv1_sva.sv
// TPU control assertions

`timescale 1ns/10ps

module tb_tpuv1_sva
    import tpu_op_pkg::*;
(
    input logic              clk,
    input logic              arst_n,
    input logic              wr_a,
    input logic              wr_b,
    input logic              wr_c,
    input logic              rd_c,
    input logic              step_en,
    input logic              clr_steps,
    input logic [step_w-1:0] step
);

    int unsigned fail_count = 0;

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !(wr_a || wr_b || wr_c || rd_c || step_en || clr_steps))
        else begin
            fail_count++;
            $error("strobe active during reset");
        end

    a_step_range: assert property (@(posedge clk) disable iff (!arst_n) step <= n_steps)
        else begin
            fail_count++;
            $error("step count above %0d", n_steps);
        end

    // clr_steps travels with the write strobes
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({wr_a, wr_b, wr_c, rd_c, step_en}))
        else begin
            fail_count++;
            $error("more than one strobe active");
        end

endmodule

bind tpuv1 tb_tpuv1_sva u_sva (
    .clk       (clk),
    .arst_n    (arst_n),
    .wr_a      (wr_a),
    .wr_b      (wr_b),
    .wr_c      (wr_c),
    .rd_c      (rd_c),
    .step_en   (step_en),
    .clr_steps (clr_steps),
    .step      (step)
);

// File: tb_tpuv1.sv
// TPU matrix multiply testbench

`timescale 1ns/10ps

module tb_tpuv1
    import tpu_cfg_pkg::*;
    import tpu_op_pkg::*;
;

    // reset, then cycles of tests 1 to 6 with worst case idle cycles in test 6
    localparam int max_cycles = 2 * (10 + 16 + 54 + 55 + 47 + 23 + 128);

    logic             clk;
    logic             arst_n;
    logic             hl;
    half_row_t        v_high;
    half_row_t        v_low;
    logic [idx_w-1:0] idx;
    opcode_t          opcode;
    half_row_t        data_out;

    logic [31:0] lfsr = 32'h1989eb66;
    int          cycles = 0;
    int          cnt = 0;
    int          a_m [dim][dim];
    int          b_m [dim][dim];
    int          c_m [dim][dim];
    half_row_t   last_out;

    tpuv1 dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .hl       (hl),
        .v_high   (v_high),
        .v_low    (v_low),
        .idx      (idx),
        .opcode   (opcode),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    // Fibonacci taps 32 22 2 1 with one shift per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch");
        end
    endtask

    // inputs change 1 ns after each rising edge
    task automatic cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic void add_product();
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                for (int k = 0; k < dim; k++) begin
                    c_m[i][j] += a_m[i][k] * b_m[k][j];
                end
            end
        end
    endfunction

    // random rows into A, B or the accumulators
    // any write restarts the step count
    task automatic load_rand(input opcode_t op);
        int v;
        for (int r = 0; r < dim; r++) begin
            for (int c = 0; c < dim; c++) begin
                v = int'(rand_bits(32));
                case (op)
                    writeA:  a_m[r][c] = v;
                    writeB:  b_m[r][c] = v;
                    default: c_m[r][c] = v;
                endcase
                if (c >= half) v_high.w[c-half] = v;
                else v_low.w[c] = v;
            end
            opcode = op;
            idx    = idx_w'(r);
            cycle();
        end
        opcode = nop;
        cnt    = 0;
    endtask

    task automatic step_cycles(input int n);
        opcode = systolic_step;
        repeat (n) begin
            cycle();
            if (cnt < int'(n_steps)) begin
                cnt++;
                if (cnt == int'(n_steps)) add_product();
            end
        end
        opcode = nop;
    endtask

    task automatic run_matmul();
        int n;
        opcode = matmul;
        cycle();
        opcode = nop;
        // only the missing steps run and RUN lasts at least one cycle
        n = (cnt < int'(n_steps)) ? int'(n_steps) - cnt : 1;
        if (cnt < int'(n_steps)) add_product();
        cnt = int'(n_steps);
        repeat (n) cycle();
    endtask

    task automatic read_half(input logic [idx_w-1:0] ix, input logic h);
        half_row_t exp;
        for (int j = 0; j < half; j++) begin
            exp.w[j] = c_m[ix[row_w-1:0]][j + (h ? half : 0)];
        end
        opcode = readC;
        idx    = ix;
        hl     = h;
        cycle();
        opcode = nop;
        check(data_out, exp, $sformatf("readC row %0d hl %0d", ix[row_w-1:0], h));
        last_out = exp;
    endtask

    task automatic read_all();
        for (int r = 0; r < dim; r++) begin
            read_half(idx_w'(r), 1'b1);
            read_half(idx_w'(r), 1'b0);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        opcode = nop;
        idx    = '0;
        hl     = 1'b0;
        v_high = '0;
        v_low  = '0;
        c_m    = '{default: '{default: 0}};
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        read_all();

        load_rand(writeA);
        load_rand(writeB);
        step_cycles(22);
        read_all();

        // accumulators keep the previous result
        load_rand(writeA);
        load_rand(writeB);
        run_matmul();
        read_all();

        load_rand(writeC);
        step_cycles(10);
        run_matmul();
        read_all();

        // count is saturated so nothing more is added
        step_cycles(5);
        run_matmul();
        read_all();

        repeat (64) begin
            logic [idx_w-1:0] rd_idx;
            logic             rd_hl;
            if (rand_bits(1) != 0) begin
                // readout must not follow idx or hl without a readC
                idx = idx_w'(rand_bits(idx_w));
                hl  = (rand_bits(1) != 0);
                cycle();
                check(data_out, last_out, "data_out hold on nop");
            end
            rd_idx = idx_w'(rand_bits(idx_w));
            rd_hl  = (rand_bits(1) != 0);
            read_half(rd_idx, rd_hl);
        end

        if (dut.u_sva.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures in the bound checker");
        end
    end

endmodule

// File: vlog.f
tpu_cfg_pkg.sv
tpu_op_pkg.sv
tpu_operand_mem.sv
tpu_step_counter.sv
tpu_sequencer.sv
tpu_mac_pe.sv
tpu_systolic_array.sv
tpuv1.sv
tb_tpuv1_sva.sv
tb_tpuv1.sv

// File: Bender.yml
package:
  name: tpuv1

sources:
  - tpu_cfg_pkg.sv
  - tpu_op_pkg.sv
  - tpu_operand_mem.sv
  - tpu_step_counter.sv
  - tpu_sequencer.sv
  - tpu_mac_pe.sv
  - tpu_systolic_array.sv
  - tpuv1.sv
  - target: test
    files:
      - tb_tpuv1_sva.sv
      - tb_tpuv1.sv
